//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mmio_bridge_tb -Mdir build -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./build/Vmmio_bridge_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

//--- sim/mmio_bridge_properties.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_bridge_properties
  (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              fwd_v_i,
    input logic              fwd_ready_o,
    input logic              pkt_v_o,
    input logic              pkt_ready_i,
    input mmio_pkg::mc_op_e  pkt_op_o,
    input mmio_pkg::epa_t    pkt_addr_o,
    input mmio_pkg::x_cord_t pkt_x_o,
    input mmio_pkg::y_cord_t pkt_y_o,
    input mmio_pkg::mask_t   pkt_mask_o,
    input mmio_pkg::word_t   pkt_data_o,
    input logic              pkt_load_byte_o,
    input logic              pkt_load_hex_o,
    input logic [1:0]        pkt_part_sel_o,
    input mmio_pkg::tag_t    pkt_tag_o,
    input logic              rev_v_o,
    input logic              rev_ready_i,
    input logic              rev_write_o,
    input mmio_pkg::size_t   rev_size_o,
    input mmio_pkg::word_t   rev_data_o
  );

  int failure_count = 0;

  // Stalled packet keeps its payload
  pkt_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pkt_v_o && !pkt_ready_i |=> pkt_v_o && $stable({pkt_op_o, pkt_addr_o, pkt_x_o,
                                                     pkt_y_o, pkt_mask_o, pkt_data_o,
                                                     pkt_load_byte_o, pkt_load_hex_o,
                                                     pkt_part_sel_o, pkt_tag_o}))
    else
    begin
      failure_count++;
      $error("network packet changed while stalled");
    end

  rev_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_v_o && !rev_ready_i |=> rev_v_o && $stable({rev_write_o, rev_size_o, rev_data_o}))
    else
    begin
      failure_count++;
      $error("processor response changed while stalled");
    end

  // Both valids idle and all tags free right after reset
  reset_idle_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !pkt_v_o && !rev_v_o && fwd_ready_o)
    else
    begin
      failure_count++;
      $error("bridge not idle after reset");
    end

  issue_timing_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fwd_v_i && fwd_ready_o |=> pkt_v_o)
    else
    begin
      failure_count++;
      $error("packet did not follow the processor transfer");
    end

endmodule

bind mmio_bridge mmio_bridge_properties u_properties
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fwd_v_i         (fwd_v_i),
    .fwd_ready_o     (fwd_ready_o),
    .pkt_v_o         (pkt_v_o),
    .pkt_ready_i     (pkt_ready_i),
    .pkt_op_o        (pkt_op_o),
    .pkt_addr_o      (pkt_addr_o),
    .pkt_x_o         (pkt_x_o),
    .pkt_y_o         (pkt_y_o),
    .pkt_mask_o      (pkt_mask_o),
    .pkt_data_o      (pkt_data_o),
    .pkt_load_byte_o (pkt_load_byte_o),
    .pkt_load_hex_o  (pkt_load_hex_o),
    .pkt_part_sel_o  (pkt_part_sel_o),
    .pkt_tag_o       (pkt_tag_o),
    .rev_v_o         (rev_v_o),
    .rev_ready_i     (rev_ready_i),
    .rev_write_o     (rev_write_o),
    .rev_size_o      (rev_size_o),
    .rev_data_o      (rev_data_o)
  );

`default_nettype wire

//--- sim/mmio_bridge_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_bridge_tb;

  localparam int SEED        = 32'h0b3a_e78e;
  localparam int TOTAL_TXNS  = 40 + 40 + 30 + 40 + 4;
  localparam int LIMIT_TICKS = TOTAL_TXNS * 200;

  typedef struct {
    mmio_pkg::mc_op_e  op;
    mmio_pkg::epa_t    epa;
    mmio_pkg::x_cord_t x;
    mmio_pkg::y_cord_t y;
    mmio_pkg::mask_t   mask;
    mmio_pkg::word_t   data;
    logic              load_byte;
    logic              load_hex;
    logic [1:0]        part_sel;
    mmio_pkg::tag_t    tag;
  } pkt_t;

  typedef struct {
    mmio_pkg::tag_t  tag;
    logic            write;
    mmio_pkg::size_t size;
  } rsp_t;

  logic              clk_i;
  logic              rst_n_i;
  logic              fwd_v_i;
  logic              fwd_write_i;
  mmio_pkg::size_t   fwd_size_i;
  mmio_pkg::paddr_t  fwd_addr_i;
  mmio_pkg::word_t   fwd_data_i;
  logic              fwd_ready_o;
  logic              pkt_v_o;
  mmio_pkg::mc_op_e  pkt_op_o;
  mmio_pkg::epa_t    pkt_addr_o;
  mmio_pkg::x_cord_t pkt_x_o;
  mmio_pkg::y_cord_t pkt_y_o;
  mmio_pkg::mask_t   pkt_mask_o;
  mmio_pkg::word_t   pkt_data_o;
  logic              pkt_load_byte_o;
  logic              pkt_load_hex_o;
  logic [1:0]        pkt_part_sel_o;
  mmio_pkg::tag_t    pkt_tag_o;
  logic              pkt_ready_i;
  logic              ret_v_i;
  mmio_pkg::tag_t    ret_tag_i;
  mmio_pkg::word_t   ret_data_i;
  logic              rev_v_o;
  logic              rev_write_o;
  mmio_pkg::size_t   rev_size_o;
  mmio_pkg::word_t   rev_data_o;
  logic              rev_ready_i;
  mmio_pkg::x_cord_t host_x_i;
  mmio_pkg::y_cord_t host_y_i;

  // Reference model state
  pkt_t            exp_pkt [$];
  rsp_t            exp_rsp [$];
  mmio_pkg::tag_t  next_tag;
  mmio_pkg::word_t ret_data_by_tag [mmio_pkg::OUTSTANDING];
  mmio_pkg::tag_t  pend_tag [$];
  int              pend_delay [$];

  // Knobs for the responder and the processor side
  int pkt_ready_pct;
  int rev_ready_pct;
  int max_delay;
  bit rev_hold;

  int check_count;
  int error_count;
  int seed_value;

  mmio_tb_clock #(.PERIOD_NS(100)) u_clock (.clk_o(clk_i));

  mmio_bridge u_mmio_bridge (.*);

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_epa(string name, mmio_pkg::epa_t exp, mmio_pkg::epa_t act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_x(string name, mmio_pkg::x_cord_t exp, mmio_pkg::x_cord_t act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_y(string name, mmio_pkg::y_cord_t exp, mmio_pkg::y_cord_t act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_op(string name, mmio_pkg::mc_op_e exp, mmio_pkg::mc_op_e act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_mask(string name, mmio_pkg::mask_t exp, mmio_pkg::mask_t act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_tag(string name, mmio_pkg::tag_t exp, mmio_pkg::tag_t act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_size(string name, mmio_pkg::size_t exp, mmio_pkg::size_t act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(string name, mmio_pkg::word_t exp, mmio_pkg::word_t act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report_failure(string msg);
    error_count++;
    $display("%s", msg);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic pkt_t model_packet(logic write, mmio_pkg::size_t size,
                                        mmio_pkg::paddr_t addr, mmio_pkg::word_t data,
                                        mmio_pkg::tag_t tag);
    pkt_t       p;
    logic [7:0] wide_mask;
    p.tag = tag;
    case (addr[39:38])
      2'b11:
      begin
        p.epa = {12'd0, addr[17:2]};
        p.x   = addr[23:18];
        p.y   = addr[30:24];
      end
      2'b10:
      begin
        p.epa = {1'b0, addr[28:2]};
        p.x   = addr[34:29];
        p.y   = {addr[37:35], 1'b0, (addr[35] ? 3'b000 : 3'b111)};
      end
      default:
      begin
        p.epa = addr[29:2];
        p.x   = host_x_i;
        p.y   = host_y_i;
      end
    endcase
    if (write)
    begin
      wide_mask   = (size == 2'd0) ? 8'h1 : (size == 2'd1) ? 8'h3 : 8'hf;
      wide_mask   = wide_mask << addr[1:0];
      p.mask      = wide_mask[3:0];
      p.op        = (p.mask == 4'hf) ? mmio_pkg::op_store : mmio_pkg::op_store_masked;
      p.data      = data;
      p.load_byte = 1'b0;
      p.load_hex  = 1'b0;
      p.part_sel  = 2'b00;
    end
    else
    begin
      p.mask      = 4'h0;
      p.op        = mmio_pkg::op_load;
      p.data      = '0;
      p.load_byte = (size == 2'd0);
      p.load_hex  = (size == 2'd1);
      p.part_sel  = addr[1:0];
    end
    return p;
  endfunction

  function automatic mmio_pkg::word_t packed_read(rsp_t r, mmio_pkg::word_t d);
    if (r.write)
      return '0;
    if (r.size == 2'd0)
      return {d[7:0], d[7:0], d[7:0], d[7:0]};
    if (r.size == 2'd1)
      return {d[15:0], d[15:0]};
    return d;
  endfunction

  //////////////////////////////////////////////////
  // Network responder
  //////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    int   ready_idx [$];
    int   pick;
    pkt_t p;
    ready_idx.delete();
    if (rst_n_i)
    begin
      if (pkt_v_o && pkt_ready_i)
      begin
        if (exp_pkt.size() == 0)
          report_failure("network packet issued with no request outstanding");
        else
        begin
          p = exp_pkt.pop_front();
          check_op("pkt_op", p.op, pkt_op_o);
          check_epa("pkt_addr", p.epa, pkt_addr_o);
          check_x("pkt_x", p.x, pkt_x_o);
          check_y("pkt_y", p.y, pkt_y_o);
          check_mask("pkt_mask", p.mask, pkt_mask_o);
          check_word("pkt_data", p.data, pkt_data_o);
          check_bit("pkt_load_byte", p.load_byte, pkt_load_byte_o);
          check_bit("pkt_load_hex", p.load_hex, pkt_load_hex_o);
          check_bit("pkt_part_sel0", p.part_sel[0], pkt_part_sel_o[0]);
          check_bit("pkt_part_sel1", p.part_sel[1], pkt_part_sel_o[1]);
          check_tag("pkt_tag", p.tag, pkt_tag_o);
          pend_tag.push_back(pkt_tag_o);
          pend_delay.push_back($urandom_range(max_delay, 0));
        end
      end
      foreach (pend_delay[i])
      begin
        if (pend_delay[i] > 0)
          pend_delay[i]--;
        else
          ready_idx.push_back(i);
      end
      if (ready_idx.size() > 0 && $urandom_range(99, 0) < 60)
      begin
        pick = ready_idx[$urandom_range(ready_idx.size() - 1, 0)];
        ret_v_i    <= 1'b1;
        ret_tag_i  <= pend_tag[pick];
        ret_data_i <= $urandom();
        ret_data_by_tag[pend_tag[pick]] = 'x;
        pend_tag.delete(pick);
        pend_delay.delete(pick);
      end
      else
        ret_v_i <= 1'b0;
      pkt_ready_i <= ($urandom_range(99, 0) < pkt_ready_pct);
    end
  end

  // Returned data becomes visible to the model once it is on the bus
  always @(posedge clk_i)
  begin
    if (rst_n_i && ret_v_i)
      ret_data_by_tag[ret_tag_i] = ret_data_i;
  end

  //////////////////////////////////////////////////
  // Processor response side
  //////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    rsp_t r;
    if (rst_n_i)
    begin
      if (rev_v_o && rev_ready_i)
      begin
        if (exp_rsp.size() == 0)
          report_failure("processor response with no request outstanding");
        else
        begin
          r = exp_rsp.pop_front();
          check_bit("rev_write", r.write, rev_write_o);
          check_size("rev_size", r.size, rev_size_o);
          check_word("rev_data", packed_read(r, ret_data_by_tag[r.tag]), rev_data_o);
        end
      end
      rev_ready_i <= !rev_hold && ($urandom_range(99, 0) < rev_ready_pct);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic send_request(logic write, mmio_pkg::size_t size,
                              mmio_pkg::paddr_t addr, mmio_pkg::word_t data);
    rsp_t r;
    @(posedge clk_i);
    fwd_v_i     <= 1'b1;
    fwd_write_i <= write;
    fwd_size_i  <= size;
    fwd_addr_i  <= addr;
    fwd_data_i  <= data;
    do
      @(posedge clk_i);
    while (!fwd_ready_o);
    exp_pkt.push_back(model_packet(write, size, addr, data, next_tag));
    r.tag   = next_tag;
    r.write = write;
    r.size  = size;
    exp_rsp.push_back(r);
    next_tag = next_tag + 1'b1;
    fwd_v_i <= 1'b0;
  endtask

  function automatic mmio_pkg::paddr_t random_addr();
    logic [1:0]  region;
    logic [37:0] offset;
    region = 2'($urandom_range(3, 0));
    offset = {6'($urandom()), $urandom()};
    return {region, offset};
  endfunction

  task automatic wait_drained();
    while (exp_rsp.size() != 0 || exp_pkt.size() != 0)
      @(posedge clk_i);
  endtask

  task automatic run_random(string name, int count, int write_pct);
    int start_errors;
    start_errors = error_count;
    for (int i = 0; i < count; i++)
      send_request($urandom_range(99, 0) < write_pct, $urandom_range(2, 0),
                   random_addr(), $urandom());
    wait_drained();
    $display("test %s: %0d requests, %0d errors", name, count, error_count - start_errors);
  endtask

  task automatic run_outstanding();
    int start_errors;
    int waited;
    start_errors  = error_count;
    rev_hold      = 1'b1;
    pkt_ready_pct = 100;
    for (int i = 0; i < mmio_pkg::OUTSTANDING; i++)
      send_request(1'b0, 2'd2, random_addr(), '0);
    repeat (3)
    begin
      @(posedge clk_i);
      if (fwd_ready_o)
        report_failure("fwd_ready_o stayed high with four requests unanswered");
    end
    rev_hold = 1'b0;
    waited   = 0;
    while (!fwd_ready_o && waited < 200)
    begin
      @(posedge clk_i);
      waited++;
    end
    if (!fwd_ready_o)
      report_failure("fwd_ready_o did not recover after responses drained");
    wait_drained();
    $display("test outstanding_limit: %0d requests, %0d errors", mmio_pkg::OUTSTANDING,
             error_count - start_errors);
  endtask

  // Watchdog
  initial
  begin
    repeat (LIMIT_TICKS) @(posedge clk_i);
    $display("timeout: the bridge stopped making progress before all tests finished");
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    seed_value    = $urandom(SEED);
    rst_n_i       = 1'b0;
    fwd_v_i       = 1'b0;
    fwd_write_i   = 1'b0;
    fwd_size_i    = '0;
    fwd_addr_i    = '0;
    fwd_data_i    = '0;
    pkt_ready_i   = 1'b0;
    ret_v_i       = 1'b0;
    ret_tag_i     = '0;
    ret_data_i    = '0;
    rev_ready_i   = 1'b0;
    host_x_i      = 6'h15;
    host_y_i      = 7'h4a;
    next_tag      = '0;
    pkt_ready_pct = 80;
    rev_ready_pct = 80;
    max_delay     = 3;
    rev_hold      = 1'b0;
    check_count   = 0;
    error_count   = 0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);

    run_random("address_decode", 40, 0);
    run_random("operation_encode", 40, 50);
    pkt_ready_pct = 30;
    run_random("issue_backpressure", 30, 50);
    pkt_ready_pct = 90;
    rev_ready_pct = 50;
    max_delay     = 20;
    run_random("in_order_return", 40, 50);
    max_delay = 3;
    run_outstanding();

    error_count += u_mmio_bridge.u_properties.failure_count;
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/mmio_tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_tb_clock
  #(
    parameter int PERIOD_NS = 100
  )
  (
    output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS/2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- src/mmio_addr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_addr_decode
  (
    input  logic              [mmio_pkg::PADDR_WIDTH-1:0] fwd_addr_i,
    input  mmio_pkg::x_cord_t host_x_i,
    input  mmio_pkg::y_cord_t host_y_i,
    output mmio_pkg::target_e target_o,
    output mmio_pkg::epa_t    epa_o,
    output mmio_pkg::x_cord_t x_o,
    output mmio_pkg::y_cord_t y_o
  );

  logic [1:0]                           region;
  logic [mmio_pkg::POD_Y_WIDTH-1:0]     vcache_pod_y;
  logic [mmio_pkg::Y_SUBCORD_WIDTH-1:0] vcache_subcord;

  assign region = fwd_addr_i[mmio_pkg::PADDR_WIDTH-1 -: 2];

  // Vcache pods sit on even rows, so the low pod bit is always zero
  assign vcache_pod_y = {fwd_addr_i[mmio_pkg::VCACHE_ADDR_WIDTH + mmio_pkg::X_CORD_WIDTH
                                    +: mmio_pkg::POD_Y_WIDTH-1], 1'b0};

  // North or south row of the pod
  assign vcache_subcord = (vcache_pod_y[1] == 1'b0) ? '1 : '0;

  always_comb
  begin
    case (region)
      mmio_pkg::REGION_TILE:
      begin
        target_o = mmio_pkg::tgt_tile;
        epa_o    = mmio_pkg::epa_t'(fwd_addr_i[mmio_pkg::TILE_ADDR_WIDTH-1:2]);
        x_o      = fwd_addr_i[mmio_pkg::TILE_ADDR_WIDTH +: mmio_pkg::X_CORD_WIDTH];
        y_o      = fwd_addr_i[mmio_pkg::TILE_ADDR_WIDTH + mmio_pkg::X_CORD_WIDTH
                              +: mmio_pkg::Y_CORD_WIDTH];
      end
      mmio_pkg::REGION_VCACHE:
      begin
        target_o = mmio_pkg::tgt_vcache;
        epa_o    = mmio_pkg::epa_t'(fwd_addr_i[mmio_pkg::VCACHE_ADDR_WIDTH-1:2]);
        x_o      = fwd_addr_i[mmio_pkg::VCACHE_ADDR_WIDTH +: mmio_pkg::X_CORD_WIDTH];
        y_o      = {vcache_pod_y, vcache_subcord};
      end
      default:
      begin
        // Everything else goes to the host
        target_o = mmio_pkg::tgt_host;
        epa_o    = fwd_addr_i[2 +: mmio_pkg::EPA_WIDTH];
        x_o      = host_x_i;
        y_o      = host_y_i;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/mmio_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_bridge
  (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Processor request
    input  logic              fwd_v_i,
    input  logic              fwd_write_i,
    input  mmio_pkg::size_t   fwd_size_i,
    input  mmio_pkg::paddr_t  fwd_addr_i,
    input  mmio_pkg::word_t   fwd_data_i,
    output logic              fwd_ready_o,

    // Network request
    output logic              pkt_v_o,
    output mmio_pkg::mc_op_e  pkt_op_o,
    output mmio_pkg::epa_t    pkt_addr_o,
    output mmio_pkg::x_cord_t pkt_x_o,
    output mmio_pkg::y_cord_t pkt_y_o,
    output mmio_pkg::mask_t   pkt_mask_o,
    output mmio_pkg::word_t   pkt_data_o,
    output logic              pkt_load_byte_o,
    output logic              pkt_load_hex_o,
    output logic [1:0]        pkt_part_sel_o,
    output mmio_pkg::tag_t    pkt_tag_o,
    input  logic              pkt_ready_i,

    // Network response, always accepted
    input  logic              ret_v_i,
    input  mmio_pkg::tag_t    ret_tag_i,
    input  mmio_pkg::word_t   ret_data_i,

    // Processor response
    output logic              rev_v_o,
    output logic              rev_write_o,
    output mmio_pkg::size_t   rev_size_o,
    output mmio_pkg::word_t   rev_data_o,
    input  logic              rev_ready_i,

    input  mmio_pkg::x_cord_t host_x_i,
    input  mmio_pkg::y_cord_t host_y_i
  );

  mmio_pkg::target_e target;
  mmio_pkg::epa_t    epa;
  mmio_pkg::x_cord_t x_cord;
  mmio_pkg::y_cord_t y_cord;
  mmio_pkg::mc_op_e  op;
  mmio_pkg::mask_t   mask;
  mmio_pkg::tag_t    tag;
  logic              load_byte;
  logic              load_hex;
  logic              tag_free;
  logic              can_take;
  logic              take;

  assign fwd_ready_o = tag_free & can_take;
  assign take        = fwd_v_i & fwd_ready_o;

  mmio_addr_decode u_addr_decode
  (
    .fwd_addr_i (fwd_addr_i),
    .host_x_i   (host_x_i),
    .host_y_i   (host_y_i),
    .target_o   (target),
    .epa_o      (epa),
    .x_o        (x_cord),
    .y_o        (y_cord)
  );

  mmio_op_encode u_op_encode
  (
    .fwd_write_i (fwd_write_i),
    .fwd_size_i  (fwd_size_i),
    .part_sel_i  (fwd_addr_i[1:0]),
    .op_o        (op),
    .mask_o      (mask),
    .load_byte_o (load_byte),
    .load_hex_o  (load_hex)
  );

  mmio_packet_issue u_packet_issue
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .take_i          (take),
    .target_i        (target),
    .epa_i           (epa),
    .x_i             (x_cord),
    .y_i             (y_cord),
    .op_i            (op),
    .mask_i          (mask),
    .load_byte_i     (load_byte),
    .load_hex_i      (load_hex),
    .part_sel_i      (fwd_addr_i[1:0]),
    .data_i          (fwd_data_i),
    .tag_i           (tag),
    .can_take_o      (can_take),
    .pkt_v_o         (pkt_v_o),
    .pkt_op_o        (pkt_op_o),
    .pkt_addr_o      (pkt_addr_o),
    .pkt_x_o         (pkt_x_o),
    .pkt_y_o         (pkt_y_o),
    .pkt_mask_o      (pkt_mask_o),
    .pkt_data_o      (pkt_data_o),
    .pkt_load_byte_o (pkt_load_byte_o),
    .pkt_load_hex_o  (pkt_load_hex_o),
    .pkt_part_sel_o  (pkt_part_sel_o),
    .pkt_tag_o       (pkt_tag_o),
    .pkt_ready_i     (pkt_ready_i)
  );

  mmio_reorder_buffer u_reorder_buffer
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .alloc_i       (take),
    .alloc_write_i (fwd_write_i),
    .alloc_size_i  (fwd_size_i),
    .tag_o         (tag),
    .tag_free_o    (tag_free),
    .ret_v_i       (ret_v_i),
    .ret_tag_i     (ret_tag_i),
    .ret_data_i    (ret_data_i),
    .rev_v_o       (rev_v_o),
    .rev_write_o   (rev_write_o),
    .rev_size_o    (rev_size_o),
    .rev_data_o    (rev_data_o),
    .rev_ready_i   (rev_ready_i)
  );

endmodule

`default_nettype wire

//--- src/mmio_op_encode.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_op_encode
  (
    input  logic             fwd_write_i,
    input  mmio_pkg::size_t  fwd_size_i,
    input  logic [1:0]       part_sel_i,
    output mmio_pkg::mc_op_e op_o,
    output mmio_pkg::mask_t  mask_o,
    output logic             load_byte_o,
    output logic             load_hex_o
  );

  mmio_pkg::mask_t base_mask;
  mmio_pkg::mask_t store_mask;

  // Byte lanes touched by the store, before alignment
  always_comb
  begin
    case (fwd_size_i)
      mmio_pkg::SIZE_BYTE: base_mask = 4'h1;
      mmio_pkg::SIZE_HALF: base_mask = 4'h3;
      default:             base_mask = 4'hf;
    endcase
  end

  // Lanes shifted past bit 3 fall off
  assign store_mask = base_mask << part_sel_i;

  always_comb
  begin
    if (fwd_write_i)
    begin
      mask_o      = store_mask;
      load_byte_o = 1'b0;
      load_hex_o  = 1'b0;
      if (store_mask == '1)
        op_o = mmio_pkg::op_store;
      else
        op_o = mmio_pkg::op_store_masked;
    end
    else
    begin
      op_o        = mmio_pkg::op_load;
      mask_o      = '0;
      load_byte_o = (fwd_size_i == mmio_pkg::SIZE_BYTE);
      load_hex_o  = (fwd_size_i == mmio_pkg::SIZE_HALF);
    end
  end

endmodule

`default_nettype wire

//--- src/mmio_packet_issue.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_packet_issue
  (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              take_i,
    input  mmio_pkg::target_e target_i,
    input  mmio_pkg::epa_t    epa_i,
    input  mmio_pkg::x_cord_t x_i,
    input  mmio_pkg::y_cord_t y_i,
    input  mmio_pkg::mc_op_e  op_i,
    input  mmio_pkg::mask_t   mask_i,
    input  logic              load_byte_i,
    input  logic              load_hex_i,
    input  logic [1:0]        part_sel_i,
    input  mmio_pkg::word_t   data_i,
    input  mmio_pkg::tag_t    tag_i,
    output logic              can_take_o,
    output logic              pkt_v_o,
    output mmio_pkg::mc_op_e  pkt_op_o,
    output mmio_pkg::epa_t    pkt_addr_o,
    output mmio_pkg::x_cord_t pkt_x_o,
    output mmio_pkg::y_cord_t pkt_y_o,
    output mmio_pkg::mask_t   pkt_mask_o,
    output mmio_pkg::word_t   pkt_data_o,
    output logic              pkt_load_byte_o,
    output logic              pkt_load_hex_o,
    output logic [1:0]        pkt_part_sel_o,
    output mmio_pkg::tag_t    pkt_tag_o,
    input  logic              pkt_ready_i
  );

  logic           is_load;
  mmio_pkg::epa_t region_epa;

  assign is_load = (op_i == mmio_pkg::op_load);

  // Trim the EPA to the word range of its region
  always_comb
  begin
    case (target_i)
      mmio_pkg::tgt_tile:
        region_epa = epa_i & mmio_pkg::epa_t'((1 << (mmio_pkg::TILE_ADDR_WIDTH-2)) - 1);
      mmio_pkg::tgt_vcache:
        region_epa = epa_i & mmio_pkg::epa_t'((1 << (mmio_pkg::VCACHE_ADDR_WIDTH-2)) - 1);
      default:
        region_epa = epa_i;
    endcase
  end

  // Free, or the held packet leaves this cycle
  assign can_take_o = ~pkt_v_o | pkt_ready_i;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pkt_v_o <= 1'b0;
    else if (take_i)
      pkt_v_o <= 1'b1;
    else if (pkt_ready_i)
      pkt_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (take_i)
    begin
      pkt_op_o        <= op_i;
      pkt_addr_o      <= region_epa;
      pkt_x_o         <= x_i;
      pkt_y_o         <= y_i;
      pkt_mask_o      <= mask_i;
      pkt_data_o      <= is_load ? '0 : data_i;
      pkt_load_byte_o <= load_byte_i;
      pkt_load_hex_o  <= load_hex_i;
      pkt_part_sel_o  <= is_load ? part_sel_i : 2'b00;
      pkt_tag_o       <= tag_i;
    end
  end

endmodule

`default_nettype wire

//--- src/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int PADDR_WIDTH     = 40;
  localparam int WORD_WIDTH      = 32;
  localparam int X_CORD_WIDTH    = 6;
  localparam int Y_CORD_WIDTH    = 7;
  localparam int POD_Y_WIDTH     = 4;
  localparam int Y_SUBCORD_WIDTH = 3;
  localparam int EPA_WIDTH       = 28;
  localparam int MASK_WIDTH      = 4;

  // Tags index the reorder buffer directly
  localparam int OUTSTANDING     = 4;
  localparam int TAG_WIDTH       = 2;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  localparam int TILE_ADDR_WIDTH   = 18;
  localparam int VCACHE_ADDR_WIDTH = 29;

  // Region select, top two bits of the processor address
  localparam logic [1:0] REGION_TILE   = 2'b11;
  localparam logic [1:0] REGION_VCACHE = 2'b10;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [PADDR_WIDTH-1:0]  paddr_t;
  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [X_CORD_WIDTH-1:0] x_cord_t;
  typedef logic [Y_CORD_WIDTH-1:0] y_cord_t;
  typedef logic [EPA_WIDTH-1:0]    epa_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;
  typedef logic [MASK_WIDTH-1:0]   mask_t;

  // Request size code
  typedef logic [1:0] size_t;

  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  typedef enum logic [1:0]
  {
    op_load         = 2'd0,
    op_store        = 2'd1,
    op_store_masked = 2'd2
  } mc_op_e;

  typedef enum logic [1:0]
  {
    tgt_tile   = 2'd0,
    tgt_vcache = 2'd1,
    tgt_host   = 2'd2
  } target_e;

endpackage

`default_nettype wire

//--- src/mmio_reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_reorder_buffer
  (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            alloc_i,
    input  logic            alloc_write_i,
    input  mmio_pkg::size_t alloc_size_i,
    output mmio_pkg::tag_t  tag_o,
    output logic            tag_free_o,
    input  logic            ret_v_i,
    input  mmio_pkg::tag_t  ret_tag_i,
    input  mmio_pkg::word_t ret_data_i,
    output logic            rev_v_o,
    output logic            rev_write_o,
    output mmio_pkg::size_t rev_size_o,
    output mmio_pkg::word_t rev_data_o,
    input  logic            rev_ready_i
  );

  // Per-tag request info and returned data
  logic            write_q [mmio_pkg::OUTSTANDING];
  mmio_pkg::size_t size_q  [mmio_pkg::OUTSTANDING];
  mmio_pkg::word_t data_q  [mmio_pkg::OUTSTANDING];

  logic [mmio_pkg::OUTSTANDING-1:0] returned_q;
  mmio_pkg::tag_t                   alloc_ptr_q;
  mmio_pkg::tag_t                   head_ptr_q;
  logic [mmio_pkg::TAG_WIDTH:0]     used_q;

  logic            release_w;
  mmio_pkg::word_t head_data;

  assign tag_o      = alloc_ptr_q;
  assign tag_free_o = (used_q != mmio_pkg::OUTSTANDING);

  assign rev_v_o   = returned_q[head_ptr_q];
  assign release_w = rev_v_o & rev_ready_i;

  //////////////////////////////////////////////////
  // Tag bookkeeping
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      alloc_ptr_q <= '0;
      head_ptr_q  <= '0;
      used_q      <= '0;
      returned_q  <= '0;
    end
    else
    begin
      if (alloc_i)
        alloc_ptr_q <= alloc_ptr_q + 1'b1;
      if (release_w)
        head_ptr_q <= head_ptr_q + 1'b1;

      case ({alloc_i, release_w})
        2'b10:   used_q <= used_q + 1'b1;
        2'b01:   used_q <= used_q - 1'b1;
        default: used_q <= used_q;
      endcase

      // Allocated and head tags never coincide while the head is live
      if (alloc_i)
        returned_q[alloc_ptr_q] <= 1'b0;
      if (ret_v_i)
        returned_q[ret_tag_i] <= 1'b1;
      if (release_w)
        returned_q[head_ptr_q] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (alloc_i)
    begin
      write_q[alloc_ptr_q] <= alloc_write_i;
      size_q[alloc_ptr_q]  <= alloc_size_i;
    end
    if (ret_v_i)
      data_q[ret_tag_i] <= ret_data_i;
  end

  //////////////////////////////////////////////////
  // Response packing
  //////////////////////////////////////////////////

  assign rev_write_o = write_q[head_ptr_q];
  assign rev_size_o  = size_q[head_ptr_q];
  assign head_data   = data_q[head_ptr_q];

  // Replicate narrow reads across the word
  always_comb
  begin
    if (rev_write_o)
      rev_data_o = '0;
    else
    begin
      case (rev_size_o)
        mmio_pkg::SIZE_BYTE: rev_data_o = {4{head_data[7:0]}};
        mmio_pkg::SIZE_HALF: rev_data_o = {2{head_data[15:0]}};
        default:             rev_data_o = head_data;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
src/mmio_pkg.sv
src/mmio_addr_decode.sv
src/mmio_op_encode.sv
src/mmio_packet_issue.sv
src/mmio_reorder_buffer.sv
src/mmio_bridge.sv
sim/mmio_tb_clock.sv
sim/mmio_bridge_properties.sv
sim/mmio_bridge_tb.sv
